// ==== compile.f ====
verilog/robPkg.sv
verilog/execPkg.sv
verilog/reorderBuffer.sv
verilog/resultArbiter.sv
verilog/execUnit.sv
verilog/outOfOrderCore.sv
bench/tbCore.sv

// ==== Bender.yml ====
package:
  name: out_of_order_core

sources:
  - files:
      - verilog/robPkg.sv
      - verilog/execPkg.sv
      - verilog/reorderBuffer.sv
      - verilog/resultArbiter.sv
      - verilog/execUnit.sv
      - verilog/outOfOrderCore.sv
  - target: test
    files:
      - bench/tbCore.sv

// ==== bench/tbCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbCore
    import robPkg::*;
    import execPkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_OPS = 250;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 20 + RESET_CYCLES;

    logic       clk;
    logic       rst;
    logic       dispatchEn;
    unitSelT    dispUnit;
    opT         dispOp;
    dataT       dispA;
    dataT       dispB;
    branchMaskT dispBranchMask;
    tagT        freeTag;
    logic       robFree;
    logic [1:0] unitBusy;
    logic       branchFreeEn;
    logic       misTaken;
    branchIdxT  branchIdx;
    logic       commitEn;
    tagT        commitTag;
    dataT       commitData;

    integer     seed;
    int         errors;
    int         cycle;
    int         issued;
    int         dispatched;
    int         committed;
    int         squashed;
    logic       sawFull;
    logic [1:0] seenBusy;
    logic       seenFree;
    // branch slots the dispatcher currently speculates on
    branchMaskT openSlots;

    // surviving ops in program order
    tagT        modelTag [$];
    dataT       modelData [$];
    branchMaskT modelMask [$];

    // slots from head to tail, squashed ones held until the head passes them
    int                  heldSlots;
    int                  headSlot;
    logic [ROB_SIZE-1:0] deadSlot;
    logic                tookOp;
    unitSelT             tookUnit;

    outOfOrderCore dut0 (
        .clk(clk),
        .rst(rst),
        .dispatchEn(dispatchEn),
        .dispUnit(dispUnit),
        .dispOp(dispOp),
        .dispA(dispA),
        .dispB(dispB),
        .dispBranchMask(dispBranchMask),
        .freeTag(freeTag),
        .robFree(robFree),
        .unitBusy(unitBusy),
        .branchFreeEn(branchFreeEn),
        .misTaken(misTaken),
        .branchIdx(branchIdx),
        .commitEn(commitEn),
        .commitTag(commitTag),
        .commitData(commitData)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] drawRandom();
        return $random(seed);
    endfunction

    // reference arithmetic with the product cut from its full 64-bit value
    function automatic dataT expectedResult(input opT op, input dataT a, input dataT b);
        logic [63:0] product;
        product = 64'(a) * 64'(b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            default: return product[31:0];
        endcase
    endfunction

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // model follows the inputs the DUT takes at this edge
    task automatic applySampled();
        tookOp = dispatchEn;
        tookUnit = dispUnit;
        if (branchFreeEn) begin
            for (int i = 0; i < modelMask.size(); i++) begin
                modelMask[i] = modelMask[i] & ~(branchMaskT'(1) << branchIdx);
            end
        end
        if (misTaken) begin
            for (int i = modelMask.size() - 1; i >= 0; i--) begin
                if (modelMask[i][branchIdx]) begin
                    deadSlot[modelTag[i] % ROB_SIZE] = 1'b1;
                    modelTag.delete(i);
                    modelData.delete(i);
                    modelMask.delete(i);
                    squashed++;
                end
            end
        end
        // a squashed slot at the head is passed over at this edge
        if (heldSlots != 0 && deadSlot[headSlot]) begin
            deadSlot[headSlot] = 1'b0;
            headSlot = (headSlot + 1) % ROB_SIZE;
            heldSlots--;
        end
        if (dispatchEn) begin
            // prefix bit over the tail index that wraps with the buffer
            modelTag.push_back(tagT'(ROB_SIZE + dispatched % ROB_SIZE));
            modelData.push_back(expectedResult(dispOp, dispA, dispB));
            modelMask.push_back(dispBranchMask);
            dispatched++;
            heldSlots++;
        end
    endtask

    // inputs chosen here are taken by the DUT one edge later
    task automatic driveNext();
        logic [31:0] rnd;
        logic        stalled;
        logic        unit;
        logic        unitFree;
        logic        room;
        rnd = drawRandom();
        // periodic window that holds every branch open so the buffer fills
        stalled = (issued < NUM_OPS) && (cycle % 256 >= 176);
        if (issued < NUM_OPS && (stalled || rnd[3:0] == 4'd0)) begin
            openSlots[rnd[5:4]] = 1'b1;
        end
        branchFreeEn <= 1'b0;
        misTaken <= 1'b0;
        if (!stalled && rnd[8:6] == 3'd0 && openSlots[rnd[10:9]]) begin
            branchIdx <= rnd[10:9];
            openSlots[rnd[10:9]] = 1'b0;
            if (issued < NUM_OPS && rnd[12:11] == 2'd0) begin
                misTaken <= 1'b1;
            end else begin
                branchFreeEn <= 1'b1;
            end
        end
        // busy and full flags seen last cycle lag by one dispatch
        unit = rnd[13];
        unitFree = !seenBusy[unit] && !(dispatchEn && dispUnit == unit);
        room = (dispatched - committed < ROB_SIZE) || (seenFree && !dispatchEn);
        if (issued < NUM_OPS && rnd[15:14] != 2'd0 && unitFree && room) begin
            dispatchEn <= 1'b1;
            dispUnit <= unit;
            dispOp <= opT'(rnd[17:16]);
            dispA <= drawRandom();
            dispB <= drawRandom();
            dispBranchMask <= branchMaskT'(drawRandom()) & openSlots;
            issued++;
        end else begin
            dispatchEn <= 1'b0;
        end
    endtask

    // a commit must carry the oldest surviving op with a clear mask
    task automatic checkCommit();
        if (commitEn && modelTag.size() == 0) begin
            errors++;
            $display("commit at %0t ns with no surviving operation left", $time);
        end else if (commitEn) begin
            compareValue("commitTag", commitTag, modelTag[0]);
            compareValue("commitData", commitData, modelData[0]);
            compareValue("branch mask at commit", modelMask[0], 0);
            void'(modelTag.pop_front());
            void'(modelData.pop_front());
            void'(modelMask.pop_front());
            committed++;
            headSlot = (headSlot + 1) % ROB_SIZE;
            heldSlots--;
        end
    endtask

    initial begin
        seed = 32'h62be_75de;
        errors = 0;
        cycle = 0;
        issued = 0;
        dispatched = 0;
        committed = 0;
        squashed = 0;
        sawFull = 1'b0;
        seenBusy = 2'b00;
        seenFree = 1'b1;
        openSlots = '0;
        heldSlots = 0;
        headSlot = 0;
        deadSlot = '0;
        tookOp = 1'b0;
        tookUnit = UNIT_LOGIC;
        rst = 1'b1;
        dispatchEn = 1'b0;
        dispUnit = UNIT_LOGIC;
        dispOp = OP_ADD;
        dispA = '0;
        dispB = '0;
        dispBranchMask = '0;
        branchFreeEn = 1'b0;
        misTaken = 1'b0;
        branchIdx = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compareValue("freeTag", freeTag, ROB_SIZE);
        compareValue("commitEn", commitEn, 0);
        compareValue("unitBusy", unitBusy, 0);
        while (dispatched < NUM_OPS || modelTag.size() != 0) begin
            @(posedge clk);
            applySampled();
            driveNext();
            @(negedge clk);
            checkCommit();
            compareValue("robFree", robFree, heldSlots != ROB_SIZE);
            if (tookOp) begin
                compareValue("unitBusy", unitBusy[tookUnit], 1'b1);
            end
            seenBusy = unitBusy;
            seenFree = robFree;
            if (!robFree) begin
                sawFull = 1'b1;
            end
            if (dispatchEn) begin
                compareValue("freeTag", freeTag, ROB_SIZE + dispatched % ROB_SIZE);
            end
            cycle++;
        end
        @(posedge clk);
        branchFreeEn <= 1'b0;
        // nothing may commit once the model is empty
        repeat (8) begin
            @(negedge clk);
            checkCommit();
        end
        compareValue("committed plus squashed", committed + squashed, NUM_OPS);
        if (!sawFull) begin
            errors++;
            $display("the reorder buffer never reported itself full");
        end
        $display("%0d dispatched, %0d committed, %0d squashed, %0d errors",
                 dispatched, committed, squashed, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, %0d operations never committed",
                 WATCHDOG_CYCLES, modelTag.size());
        $display("%0d dispatched, %0d committed, %0d squashed, %0d errors",
                 dispatched, committed, squashed, errors);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/outOfOrderCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module outOfOrderCore
    import robPkg::*;
    import execPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       dispatchEn,
    input  unitSelT    dispUnit,
    input  opT         dispOp,
    input  dataT       dispA,
    input  dataT       dispB,
    input  branchMaskT dispBranchMask,
    output tagT        freeTag,
    output logic       robFree,
    output logic [1:0] unitBusy,
    input  logic       branchFreeEn,
    input  logic       misTaken,
    input  branchIdxT  branchIdx,
    output logic       commitEn,
    output tagT        commitTag,
    output dataT       commitData
);

    logic issue0;
    logic issue1;
    logic cyc0;
    logic stb0;
    logic ack0;
    tagT  tag0;
    dataT data0;
    logic cyc1;
    logic stb1;
    logic ack1;
    tagT  tag1;
    dataT data1;
    logic wrEn;
    tagT  wrTag;
    dataT wrData;

    assign issue0 = dispatchEn & (dispUnit == UNIT_LOGIC);
    assign issue1 = dispatchEn & (dispUnit == UNIT_MUL);

    reorderBuffer #(
        .robSize(ROB_SIZE)
    ) rob0 (
        .clk(clk),
        .rst(rst),
        .wrEn(wrEn),
        .wrTag(wrTag),
        .wrData(wrData),
        .dispatchEn(dispatchEn),
        .dispBranchMask(dispBranchMask),
        .freeTag(freeTag),
        .robFree(robFree),
        .branchFreeEn(branchFreeEn),
        .misTaken(misTaken),
        .branchIdx(branchIdx),
        .commitEn(commitEn),
        .commitTag(commitTag),
        .commitData(commitData)
    );

    resultArbiter arbiter0 (
        .clk(clk),
        .rst(rst),
        .cyc0(cyc0),
        .stb0(stb0),
        .tag0(tag0),
        .data0(data0),
        .ack0(ack0),
        .cyc1(cyc1),
        .stb1(stb1),
        .tag1(tag1),
        .data1(data1),
        .ack1(ack1),
        .wrEn(wrEn),
        .wrTag(wrTag),
        .wrData(wrData)
    );

    // logic unit, one cycle
    execUnit #(
        .latency(1)
    ) unit0 (
        .clk(clk),
        .rst(rst),
        .issueEn(issue0),
        .op(dispOp),
        .a(dispA),
        .b(dispB),
        .tag(freeTag),
        .branchMask(dispBranchMask),
        .branchFreeEn(branchFreeEn),
        .misTaken(misTaken),
        .branchIdx(branchIdx),
        .busy(unitBusy[0]),
        .resCyc(cyc0),
        .resStb(stb0),
        .resTag(tag0),
        .resData(data0),
        .resAck(ack0)
    );

    // multiply unit, three cycles
    execUnit #(
        .latency(3)
    ) unit1 (
        .clk(clk),
        .rst(rst),
        .issueEn(issue1),
        .op(dispOp),
        .a(dispA),
        .b(dispB),
        .tag(freeTag),
        .branchMask(dispBranchMask),
        .branchFreeEn(branchFreeEn),
        .misTaken(misTaken),
        .branchIdx(branchIdx),
        .busy(unitBusy[1]),
        .resCyc(cyc1),
        .resStb(stb1),
        .resTag(tag1),
        .resData(data1),
        .resAck(ack1)
    );

endmodule

`default_nettype wire

// ==== verilog/execUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execUnit
    import robPkg::*;
    import execPkg::*;
#(
    parameter int latency = 1
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       issueEn,
    input  opT         op,
    input  dataT       a,
    input  dataT       b,
    input  tagT        tag,
    input  branchMaskT branchMask,
    input  logic       branchFreeEn,
    input  logic       misTaken,
    input  branchIdxT  branchIdx,
    output logic       busy,
    output logic       resCyc,
    output logic       resStb,
    output tagT        resTag,
    output dataT       resData,
    input  logic       resAck
);

    localparam int cntWidth = $clog2(latency + 1);

    logic [cntWidth-1:0] count;
    branchMaskT          mask;
    branchMaskT          freeBit;
    logic                kill;
    opT                  heldOp;
    dataT                heldA;
    dataT                heldB;
    tagT                 heldTag;

    assign freeBit = branchFreeEn ? (branchMaskT'(1) << branchIdx) : '0;
    assign kill = busy & misTaken & mask[branchIdx];

    // request once the latency has run out
    assign resCyc = busy & (count == '0);
    assign resStb = resCyc;
    assign resTag = resCyc ? heldTag : TAG_FREE;

    always_comb begin
        case (heldOp)
            OP_ADD:  resData = heldA + heldB;
            OP_SUB:  resData = heldA - heldB;
            OP_XOR:  resData = heldA ^ heldB;
            // low word of the product
            OP_MUL:  resData = heldA * heldB;
            default: resData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            count <= '0;
        end else if (issueEn) begin
            busy <= 1'b1;
            count <= cntWidth'(latency - 1);
        end else if (kill || (resStb && resAck)) begin
            busy <= 1'b0;
        end else if (busy && count != '0) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (issueEn) begin
            heldOp <= op;
            heldA <= a;
            heldB <= b;
            heldTag <= tag;
            mask <= branchMask & ~freeBit;
        end else begin
            mask <= mask & ~freeBit;
        end
    end

    // Wishbone classic: request held steady until acknowledged
    assert property (@(posedge clk) disable iff (rst)
        (resStb && !resAck && !kill) |=> (resStb && $stable(resTag) && $stable(resData)));

endmodule

`default_nettype wire

// ==== verilog/resultArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultArbiter
    import robPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic cyc0,
    input  logic stb0,
    input  tagT  tag0,
    input  dataT data0,
    output logic ack0,
    input  logic cyc1,
    input  logic stb1,
    input  tagT  tag1,
    input  dataT data1,
    output logic ack1,
    output logic wrEn,
    output tagT  wrTag,
    output dataT wrData
);

    logic req0;
    logic req1;
    // high when unit 1 took the last grant
    logic lastWinner;

    assign req0 = cyc0 & stb0;
    assign req1 = cyc1 & stb1;

    // on a tie the loser of the previous grant goes first
    assign ack0 = req0 & (~req1 | lastWinner);
    assign ack1 = req1 & (~req0 | ~lastWinner);

    assign wrEn = ack0 | ack1;
    assign wrTag = ack1 ? tag1 : tag0;
    assign wrData = ack1 ? data1 : data0;

    always_ff @(posedge clk) begin
        if (rst) begin
            lastWinner <= 1'b0;
        end else if (wrEn) begin
            lastWinner <= ack1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(ack0 && ack1));

endmodule

`default_nettype wire

// ==== verilog/reorderBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorderBuffer
    import robPkg::*;
#(
    parameter int robSize = ROB_SIZE
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       wrEn,
    input  tagT        wrTag,
    input  dataT       wrData,
    input  logic       dispatchEn,
    input  branchMaskT dispBranchMask,
    output tagT        freeTag,
    output logic       robFree,
    input  logic       branchFreeEn,
    input  logic       misTaken,
    input  branchIdxT  branchIdx,
    output logic       commitEn,
    output tagT        commitTag,
    output dataT       commitData
);

    localparam int rootWidth = $clog2(robSize);

    logic [rootWidth-1:0] head;
    logic [rootWidth-1:0] tail;
    logic [rootWidth-1:0] wrRoot;
    // slots between head and tail, passed-over ones included
    logic [rootWidth:0]   count;
    logic [robSize-1:0]   valid;
    logic [robSize-1:0]   filled;
    logic [robSize-1:0]   discard;
    logic [robSize-1:0]   ready;
    branchMaskT           mask [robSize];
    branchMaskT           nextMask [robSize];
    dataT                 data [robSize];
    branchMaskT           freeBit;
    logic                 headMove;

    function automatic logic [rootWidth-1:0] bump(input logic [rootWidth-1:0] p);
        return (p == rootWidth'(robSize - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wrRoot = wrTag[rootWidth-1:0];
    assign freeBit = branchFreeEn ? (branchMaskT'(1) << branchIdx) : '0;

    // new ops take the tail slot, prefix bit marks a live tag
    assign freeTag = {1'b1, tail};
    assign robFree = (count != (rootWidth + 1)'(robSize));

    always_comb begin
        for (int j = 0; j < robSize; j++) begin
            nextMask[j] = mask[j] & ~freeBit;
            discard[j] = valid[j] & misTaken & mask[j][branchIdx];
            ready[j] = valid[j] & filled[j] & (nextMask[j] == '0) & ~discard[j];
        end
    end

    // retire, drop a squashed head, or skip a slot freed earlier
    assign headMove = ready[head] | discard[head] | ((count != '0) & ~valid[head]);

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            valid <= '0;
            filled <= '0;
        end else begin
            if (dispatchEn) begin
                tail <= bump(tail);
            end
            if (headMove) begin
                head <= bump(head);
            end
            if (dispatchEn && !headMove) begin
                count <= count + 1'b1;
            end else if (!dispatchEn && headMove) begin
                count <= count - 1'b1;
            end
            for (int j = 0; j < robSize; j++) begin
                if (dispatchEn && tail == rootWidth'(j)) begin
                    valid[j] <= 1'b1;
                    filled[j] <= 1'b0;
                end else begin
                    valid[j] <= valid[j] & ~discard[j] & ~(headMove && head == rootWidth'(j));
                    if (wrEn && wrRoot == rootWidth'(j)) begin
                        filled[j] <= 1'b1;
                    end
                end
            end
        end
    end

    // masks and results, meaningful only while valid
    always_ff @(posedge clk) begin
        for (int j = 0; j < robSize; j++) begin
            if (dispatchEn && tail == rootWidth'(j)) begin
                mask[j] <= dispBranchMask & ~freeBit;
            end else begin
                mask[j] <= nextMask[j];
            end
            if (wrEn && wrRoot == rootWidth'(j)) begin
                data[j] <= wrData;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commitEn <= 1'b0;
            commitTag <= TAG_FREE;
            commitData <= '0;
        end else begin
            commitEn <= ready[head];
            commitTag <= ready[head] ? {1'b1, head} : TAG_FREE;
            commitData <= ready[head] ? data[head] : '0;
        end
    end

    // results only land in live entries
    assert property (@(posedge clk) disable iff (rst) wrEn |-> valid[wrRoot]);

    // dispatcher honours the full flag
    assert property (@(posedge clk) disable iff (rst) dispatchEn |-> robFree);

endmodule

`default_nettype wire

// ==== verilog/execPkg.sv ====
`default_nettype none

package execPkg;

    // operations the two units understand
    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_MUL
    } opT;

    // which unit takes a dispatched op
    typedef logic unitSelT;

    // single-cycle logic unit
    localparam unitSelT UNIT_LOGIC = 1'b0;

    // multi-cycle multiply unit
    localparam unitSelT UNIT_MUL = 1'b1;

endpackage

`default_nettype wire

// ==== verilog/robPkg.sv ====
`default_nettype none

package robPkg;

    // buffer depth, sets the tag root width
    localparam int ROB_SIZE = 8;
    localparam int ROOT_WIDTH = $clog2(ROB_SIZE);

    // tag is the entry index plus a leading valid bit
    localparam int TAG_WIDTH = ROOT_WIDTH + 1;

    typedef logic [TAG_WIDTH-1:0] tagT;

    // all-zero tag, no entry
    localparam tagT TAG_FREE = '0;

    localparam int DATA_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0] dataT;

    // outstanding branch slots
    localparam int BRANCH_DEPTH = 4;

    // bit k set: op sits under unresolved branch k
    typedef logic [BRANCH_DEPTH-1:0] branchMaskT;

    typedef logic [$clog2(BRANCH_DEPTH)-1:0] branchIdxT;

endpackage

`default_nettype wire
